// File: flist.f
+incdir+include
design/matmul_pkg.sv
design/single_port_ram.sv
design/operand_mem.sv
design/result_mem.sv
design/matmul_sequencer.sv
design/mac_array.sv
design/matmul_top.sv
sim/tb_clock_gen.sv
sim/tb_matmul.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the matrix multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_matmul -f flist.f -o Vtb_matmul
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_matmul > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run exited with status $status"
  exit 1
fi

# The log decides the result
if grep -q "^Simulation passed$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: sim/tb_matmul.sv
`default_nettype none

`include "matmul_params.svh"

module tb_matmul
  import matmul_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  typedef row_t [`MM_N-1:0] matrix_t;

  typedef enum logic [1:0] {
    FILL_IDENT,
    FILL_RAND,
    FILL_HIGH
  } fill_t;

  typedef struct packed {
    logic [8*10-1:0] name;
    fill_t           a_fill;
    fill_t           b_fill;
    logic            start_busy;
    logic            write_busy;
    logic [1:0]      exp_dones;
  } test_entry_t;

  typedef struct packed {
    int    due;
    addr_t row;
    row_t  exp;
  } pending_read_t;

  localparam int NUM_TESTS      = 6;
  localparam int RUN_CYCLES     = 10;
  localparam int READ_LATENCY   = 2;
  localparam int TIMEOUT_CYCLES = 40 * NUM_TESTS + 100;

  // name, A fill, B fill, start while busy, write while busy, dones expected
  localparam test_entry_t TESTS [NUM_TESTS] = '{
    '{"identity  ", FILL_IDENT, FILL_RAND, 1'b0, 1'b0, 2'd1},
    '{"random    ", FILL_RAND,  FILL_RAND, 1'b0, 1'b0, 2'd1},
    '{"near_max  ", FILL_HIGH,  FILL_HIGH, 1'b0, 1'b0, 2'd1},
    '{"random_2  ", FILL_RAND,  FILL_RAND, 1'b0, 1'b0, 2'd1},
    '{"start_busy", FILL_RAND,  FILL_HIGH, 1'b1, 1'b0, 2'd1},
    '{"write_busy", FILL_HIGH,  FILL_RAND, 1'b0, 1'b1, 2'd1}
  };

  localparam addr_t READ_ORDER [`MM_N] = '{4'd3, 4'd0, 4'd2, 4'd1};

  logic      clk;
  logic      reset;
  host_req_t req;
  logic      start;
  logic      done;
  row_t      rd_data;
  logic      rd_valid;

  int            cycle;
  int            errors;
  int            pass_count;
  int            fail_count;
  int            done_count;
  int            done_edge;
  logic [31:0]   rng_state;
  pending_read_t pending [$];

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  matmul_top i_matmul_top (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .start    (start),
    .done     (done),
    .rd_data  (rd_data),
    .rd_valid (rd_valid)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model and helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // C[i][j] is the sum over k of A[i][k] * B[k][j], mod 2^16
  function automatic matrix_t reference_product(input matrix_t a, input matrix_t b);
    matrix_t     c;
    logic [31:0] full;
    for (int i = 0; i < `MM_N; i++) begin
      for (int j = 0; j < `MM_N; j++) begin
        c[i][j] = '0;
        for (int k = 0; k < `MM_N; k++) begin
          full    = 32'(a[i][k]) * 32'(b[k][j]);
          c[i][j] = c[i][j] + full[15:0];
        end
      end
    end
    return c;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic fill_matrix(input fill_t kind, output matrix_t m);
    for (int r = 0; r < `MM_N; r++) begin
      for (int c = 0; c < `MM_N; c++) begin
        rng_state = xorshift32(rng_state);
        case (kind)
          FILL_IDENT: m[r][c] = (r == c) ? 16'd1 : 16'd0;
          FILL_HIGH:  m[r][c] = 16'hFFFF - {12'd0, rng_state[3:0]};
          default:    m[r][c] = rng_state[15:0];
        endcase
      end
    end
  endtask

  task automatic send_request(input host_op_t op, input addr_t addr, input row_t data);
    @(posedge clk);
    req <= '{op: op, addr: addr, data: data};
  endtask

  task automatic report_test(input int idx, input logic [8*10-1:0] name,
                             input int errors_before);
    if (errors == errors_before) begin
      pass_count++;
      $display("test %0d %s ok", idx, name);
    end else begin
      fail_count++;
      $display("test %0d %s FAILED with %0d errors", idx, name, errors - errors_before);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // One table entry loads the operands, runs and reads back
  //////////////////////////////////////////////////////////////////////

  task automatic run_test(input int idx, input test_entry_t t);
    matrix_t       a;
    matrix_t       b;
    matrix_t       c_exp;
    row_t          col;
    pending_read_t rd;
    host_op_t      junk_op;
    int            start_edge;
    int            dones_before;
    int            errors_before;
    int            step;
    int            num_runs;

    errors_before = errors;
    num_runs      = t.write_busy ? 2 : 1;
    fill_matrix(t.a_fill, a);
    fill_matrix(t.b_fill, b);
    c_exp = reference_product(a, b);

    // A words are columns of A, B words are rows of B
    for (int k = 0; k < `MM_N; k++) begin
      for (int i = 0; i < `MM_N; i++) begin
        col[i] = a[i][k];
      end
      send_request(OP_WRITE_A, addr_t'(k), col);
      send_request(OP_WRITE_B, addr_t'(k), b[k]);
    end
    send_request(OP_NONE, '0, '0);

    // A second run on the same operands exposes any write that landed
    for (int run_num = 0; run_num < num_runs; run_num++) begin
      // Start is driven here and sampled at the next edge
      @(posedge clk);
      start <= 1'b1;
      start_edge   = cycle + 2;
      dones_before = done_count;
      step         = 0;
      while (done_count == dones_before) begin
        @(posedge clk);
        start <= t.start_busy && (step == 2);
        rng_state = xorshift32(rng_state);
        if (step % 2 == 1) begin
          junk_op = OP_WRITE_A;
        end else begin
          junk_op = OP_WRITE_B;
        end
        if (t.write_busy && run_num == 0 && step >= 1 && step <= 4) begin
          req <= '{op: junk_op, addr: addr_t'(step - 1), data: {`MM_N{rng_state[15:0]}}};
        end else begin
          req <= '{op: OP_NONE, addr: '0, data: '0};
        end
        step++;
      end
      // FEED 4 + WAIT 2 + WRITE 4
      check_value("done edge", 64'(start_edge + RUN_CYCLES), 64'(done_edge));

      // Back-to-back C reads on consecutive cycles
      for (int r = 0; r < `MM_N; r++) begin
        @(posedge clk);
        req <= '{op: OP_READ_C, addr: READ_ORDER[r], data: '0};
        rd.due = cycle + 2 + READ_LATENCY;
        rd.row = READ_ORDER[r];
        rd.exp = c_exp[READ_ORDER[r][1:0]];
        pending.push_back(rd);
      end
      send_request(OP_NONE, '0, '0);
      while (pending.size() != 0) begin
        @(posedge clk);
      end
      repeat (4) @(posedge clk);
      check_value("done count", 64'(t.exp_dones), 64'(done_count - dones_before));
    end
    report_test(idx, t.name, errors_before);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output monitor and cycle limit
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    pending_read_t rd;
    if (reset === 1'b0) begin
      // done is sampled by the host at the next rising edge
      if (done === 1'b1) begin
        done_count++;
        done_edge = cycle + 1;
      end
      if (rd_valid === 1'b1) begin
        if (pending.size() == 0) begin
          $display("rd_valid pulsed with no C read outstanding at cycle %0d", cycle);
          errors++;
        end else begin
          rd = pending.pop_front();
          check_value($sformatf("rd_valid edge row %0d", rd.row), 64'(rd.due), 64'(cycle));
          check_value($sformatf("rd_data row %0d", rd.row), rd.exp, rd_data);
        end
      end else if (pending.size() != 0 && pending[0].due <= cycle) begin
        $display("no rd_valid arrived for the C read of row %0d", pending[0].row);
        errors++;
        void'(pending.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    int errors_before;
    req        = '0;
    start      = 1'b0;
    rng_state  = 32'h8491;
    cycle      = 0;
    errors     = 0;
    pass_count = 0;
    fail_count = 0;
    done_count = 0;
    done_edge  = 0;
    while (reset !== 1'b0) begin
      @(posedge clk);
    end

    // Quiet after reset
    errors_before = errors;
    repeat (8) @(posedge clk);
    check_value("done count", 64'd0, 64'(done_count));
    report_test(0, "idle_reset", errors_before);

    for (int n = 0; n < NUM_TESTS; n++) begin
      run_test(n + 1, TESTS[n]);
    end

    $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD  = 10;
  localparam int RESET_CYCLES = 3;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset held over the first three rising edges
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: design/matmul_top.sv
`default_nettype none

module matmul_top
  import matmul_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  host_req_t req,
  input  logic      start,
  output logic      done,
  output row_t      rd_data,
  output logic      rd_valid
);

  logic        busy;
  addr_t       eng_addr;
  mac_ctl_t    mac_ctl;
  result_wr_t  wr;
  row_t        a_row;
  row_t        b_row;
  acc_matrix_t acc;
  logic        a_we;
  logic        b_we;
  logic        c_rd_req;

  ////////////////////////////////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////////////////////////////////

  assign a_we     = (req.op == OP_WRITE_A);
  assign b_we     = (req.op == OP_WRITE_B);
  // C reads are dropped during a run
  assign c_rd_req = (req.op == OP_READ_C) && !busy;

  ////////////////////////////////////////////////////////////////////
  // Operand memories
  ////////////////////////////////////////////////////////////////////

  // A holds columns of A
  operand_mem u_a_mem (
    .clk       (clk),
    .reset     (reset),
    .host_we   (a_we),
    .host_addr (req.addr),
    .host_data (req.data),
    .busy      (busy),
    .eng_addr  (eng_addr),
    .rd_row    (a_row)
  );

  // B holds rows of B
  operand_mem u_b_mem (
    .clk       (clk),
    .reset     (reset),
    .host_we   (b_we),
    .host_addr (req.addr),
    .host_data (req.data),
    .busy      (busy),
    .eng_addr  (eng_addr),
    .rd_row    (b_row)
  );

  ////////////////////////////////////////////////////////////////////
  // Engine and result memory
  ////////////////////////////////////////////////////////////////////

  matmul_sequencer u_sequencer (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .busy     (busy),
    .eng_addr (eng_addr),
    .mac_ctl  (mac_ctl),
    .wr       (wr),
    .done     (done)
  );

  mac_array u_mac_array (
    .clk     (clk),
    .reset   (reset),
    .mac_ctl (mac_ctl),
    .a_col   (a_row),
    .b_row   (b_row),
    .acc     (acc)
  );

  result_mem u_c_mem (
    .clk       (clk),
    .reset     (reset),
    .rd_req    (c_rd_req),
    .host_addr (req.addr),
    .wr        (wr),
    .acc       (acc),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid)
  );

endmodule

`default_nettype wire

// File: design/mac_array.sv
`default_nettype none

`include "matmul_params.svh"

module mac_array
  import matmul_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  mac_ctl_t    mac_ctl,
  input  row_t        a_col,
  input  row_t        b_row,
  output acc_matrix_t acc
);

  acc_matrix_t prod;
  acc_matrix_t acc_q;

  ////////////////////////////////////////////////////////////////////
  // Outer product of one A column and one B row
  ////////////////////////////////////////////////////////////////////

  // Products are kept to 16 bits, so the sum wraps mod 2^16
  always_comb begin
    for (int i = 0; i < `MM_N; i++) begin
      for (int j = 0; j < `MM_N; j++) begin
        prod[i][j] = a_col[i] * b_row[j];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Accumulators
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || mac_ctl.clear) begin
      acc_q <= '0;
    end else if (mac_ctl.acc_en) begin
      for (int i = 0; i < `MM_N; i++) begin
        for (int j = 0; j < `MM_N; j++) begin
          acc_q[i][j] <= acc_q[i][j] + prod[i][j];
        end
      end
    end
  end

  // Row i of the grid is row i of C
  assign acc = acc_q;

endmodule

`default_nettype wire

// File: design/matmul_sequencer.sv
`default_nettype none

`include "matmul_params.svh"

module matmul_sequencer
  import matmul_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       start,
  output logic       busy,
  output addr_t      eng_addr,
  output mac_ctl_t   mac_ctl,
  output result_wr_t wr,
  output logic       done
);

  // Last step index of each phase
  localparam logic [1:0] FEED_LAST  = 2'(`MM_N - 1);
  localparam logic [1:0] WAIT_LAST  = 2'd1;
  localparam logic [1:0] WRITE_LAST = 2'(`MM_N - 1);

  seq_state_t state;
  logic [1:0] step;
  logic       feed_d1;
  mac_ctl_t   mac_ctl_q;

  ////////////////////////////////////////////////////////////////////
  // Run FSM, 4 FEED + 2 WAIT + 4 WRITE cycles
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      step  <= 2'd0;
    end else begin
      case (state)
        IDLE: begin
          step <= 2'd0;
          if (start) begin
            state <= FEED;
          end
        end
        FEED: begin
          if (step == FEED_LAST) begin
            state <= WAIT;
            step  <= 2'd0;
          end else begin
            step <= step + 2'd1;
          end
        end
        // Lets the last operand rows drain into the array
        WAIT: begin
          if (step == WAIT_LAST) begin
            state <= WRITE;
            step  <= 2'd0;
          end else begin
            step <= step + 2'd1;
          end
        end
        WRITE: begin
          if (step == WRITE_LAST) begin
            state <= IDLE;
            step  <= 2'd0;
          end else begin
            step <= step + 2'd1;
          end
        end
        default: begin
          state <= IDLE;
          step  <= 2'd0;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // MAC control
  ////////////////////////////////////////////////////////////////////

  // Operand rows arrive two cycles after their address
  always_ff @(posedge clk) begin
    if (reset) begin
      feed_d1   <= 1'b0;
      mac_ctl_q <= '0;
    end else begin
      feed_d1          <= (state == FEED);
      mac_ctl_q.acc_en <= feed_d1;
      mac_ctl_q.clear  <= (state == IDLE) && start;
    end
  end

  assign mac_ctl  = mac_ctl_q;
  assign busy     = (state != IDLE);
  assign eng_addr = (state == FEED) ? addr_t'(step) : '0;

  // Write-back of C rows 0..3, done on the last one
  assign wr   = '{we: (state == WRITE), row: addr_t'(step)};
  assign done = (state == WRITE) && (step == WRITE_LAST);

endmodule

`default_nettype wire

// File: design/result_mem.sv
`default_nettype none

`include "matmul_params.svh"

module result_mem
  import matmul_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        rd_req,
  input  addr_t       host_addr,
  input  result_wr_t  wr,
  input  acc_matrix_t acc,
  output row_t        rd_data,
  output logic        rd_valid
);

  localparam int ROW_BITS = $clog2(`MM_N);

  addr_t      host_addr_q;
  logic [1:0] rd_pipe;
  addr_t      ram_addr;
  row_t       ram_wdata;
  row_t       ram_rdata;

  ////////////////////////////////////////////////////////////////////
  // Address select, write-back has priority
  ////////////////////////////////////////////////////////////////////

  assign ram_addr  = wr.we ? wr.row : host_addr_q;
  assign ram_wdata = acc[wr.row[ROW_BITS-1:0]];

  single_port_ram u_ram (
    .clk   (clk),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .we    (wr.we),
    .rdata (ram_rdata)
  );

  ////////////////////////////////////////////////////////////////////
  // Host read pipeline
  ////////////////////////////////////////////////////////////////////

  // Stage 0 follows the address register, stage 1 the RAM output
  always_ff @(posedge clk) begin
    if (reset) begin
      host_addr_q <= '0;
      rd_pipe     <= 2'b00;
      rd_valid    <= 1'b0;
    end else begin
      host_addr_q <= host_addr;
      rd_pipe     <= {rd_pipe[0], rd_req};
      rd_valid    <= rd_pipe[1];
    end
  end

  // output row holds until the next read lands
  always_ff @(posedge clk) begin
    if (rd_pipe[1]) begin
      rd_data <= ram_rdata;
    end
  end

endmodule

`default_nettype wire

// File: design/operand_mem.sv
`default_nettype none

module operand_mem
  import matmul_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  host_we,
  input  addr_t host_addr,
  input  row_t  host_data,
  input  logic  busy,
  input  addr_t eng_addr,
  output row_t  rd_row
);

  addr_t addr_q;
  logic  we_q;
  row_t  wdata_q;

  // Engine owns the address while a run is in progress
  always_ff @(posedge clk) begin
    if (reset) begin
      addr_q <= '0;
      we_q   <= 1'b0;
    end else begin
      addr_q <= busy ? eng_addr : host_addr;
      we_q   <= host_we && !busy;
    end
  end

  // Write data staged alongside the address
  always_ff @(posedge clk) begin
    wdata_q <= host_data;
  end

  single_port_ram u_ram (
    .clk   (clk),
    .addr  (addr_q),
    .wdata (wdata_q),
    .we    (we_q),
    .rdata (rd_row)
  );

endmodule

`default_nettype wire

// File: design/single_port_ram.sv
`default_nettype none

`include "matmul_params.svh"

module single_port_ram
  import matmul_pkg::*;
(
  input  logic  clk,
  input  addr_t addr,
  input  row_t  wdata,
  input  logic  we,
  output row_t  rdata
);

  row_t mem [0:`MM_DEPTH-1];

  // Synchronous write
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // Registered read, returns the old word on a same-address write
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

// File: design/matmul_pkg.sv
`default_nettype none

`include "matmul_params.svh"

package matmul_pkg;

  // One matrix element
  typedef logic [`MM_DWIDTH-1:0] elem_t;

  // Row-wide memory word, element 0 in the low bits
  typedef elem_t [`MM_N-1:0] row_t;

  typedef logic [`MM_AWIDTH-1:0] addr_t;

  // Host request opcodes
  typedef enum logic [1:0] {
    OP_NONE,
    OP_WRITE_A,
    OP_WRITE_B,
    OP_READ_C
  } host_op_t;

  typedef struct packed {
    host_op_t op;
    addr_t    addr;
    row_t     data;
  } host_req_t;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE,
    FEED,
    WAIT,
    WRITE
  } seq_state_t;

  typedef struct packed {
    logic clear;
    logic acc_en;
  } mac_ctl_t;

  // C write-back request
  typedef struct packed {
    logic  we;
    addr_t row;
  } result_wr_t;

  // Full accumulator grid, row i holds C row i
  typedef row_t [`MM_N-1:0] acc_matrix_t;

endpackage

`default_nettype wire

// File: include/matmul_params.svh
`ifndef MATMUL_PARAMS_SVH
`define MATMUL_PARAMS_SVH

////////////////////////////////////////////////////////////////////////
// Matrix multiplier sizes
////////////////////////////////////////////////////////////////////////

// Element width in bits
`define MM_DWIDTH 16

// Matrix dimension, also the number of elements per memory word
`define MM_N 4

// Memory address width and depth
`define MM_AWIDTH 4
`define MM_DEPTH 16

`endif
